// ==== common/frame_mixer_pkg.sv ====
package frame_mixer_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int DATA_WIDTH = 64;
  localparam int ID_WIDTH   = 8;

  localparam logic [ID_WIDTH-1:0] HEADER_ID     = 8'hFF; // Top byte
  localparam logic [ID_WIDTH-1:0] FOOTER_ID     = 8'h0F; // Low byte
  localparam logic [ID_WIDTH-1:0] SUB_HEADER_ID = 8'hFE; // Top byte
  localparam logic [ID_WIDTH-1:0] SUB_FOOTER_ID = 8'hEF; // Low byte

  // Repair words, all bits outside the ID byte are ones
  localparam logic [DATA_WIDTH-1:0] SUB_HEADER_WORD =
    {SUB_HEADER_ID, {(DATA_WIDTH-ID_WIDTH){1'b1}}};
  localparam logic [DATA_WIDTH-1:0] SUB_FOOTER_WORD =
    {{(DATA_WIDTH-ID_WIDTH){1'b1}}, SUB_FOOTER_ID};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {WORD_DATA, WORD_HEADER, WORD_FOOTER} word_kind_e;

  typedef enum logic {OUTSIDE, INSIDE} frame_state_e;

  typedef enum logic [1:0] {IDLE, GRANT_CH0, GRANT_CH1} grant_state_e;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] word;
    logic                  valid;   // Word emitted this cycle
    logic                  last;    // Word closes a frame
    logic                  pending; // FIFO not empty
  } chan_word_t;

  // Header wins over footer, anything else is data
  function automatic word_kind_e word_kind(input logic [DATA_WIDTH-1:0] w);
    logic [ID_WIDTH-1:0] top_id;
    logic [ID_WIDTH-1:0] low_id;
    top_id = w[DATA_WIDTH-1 -: ID_WIDTH];
    low_id = w[ID_WIDTH-1:0];
    if (top_id == HEADER_ID) begin
      return WORD_HEADER;
    end
    if ((low_id == FOOTER_ID) && (w[DATA_WIDTH-1 -: 2] == 2'b11)) begin
      return WORD_FOOTER;
    end
    return WORD_DATA;
  endfunction

endpackage

// ==== channel_reader/channel_reader.sv ====
`timescale 1ns/100ps

module channel_reader
  import frame_mixer_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RESETN,
  input  logic [DATA_WIDTH-1:0] din,
  input  logic                  avail,
  input  logic                  grant,
  input  logic                  ready,
  output logic                  re,
  output chan_word_t            out
);

  frame_state_e state;
  frame_state_e state_nxt;
  word_kind_e   kind;

  logic emit;
  logic need_sub_header;
  logic need_sub_footer;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Head word classification
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign kind = word_kind(din);

  // One word per cycle while granted and downstream has room
  assign emit = grant & ready & avail;

  // Data or footer outside a frame lost its header
  assign need_sub_header = (state == OUTSIDE) && (kind != WORD_HEADER);

  // Header inside a frame means the footer went missing
  assign need_sub_footer = (state == INSIDE) && (kind == WORD_HEADER);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Emission and pop
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    out.word    = din;
    out.valid   = emit;
    out.last    = 1'b0;
    out.pending = avail;
    re          = 1'b0;
    if (emit) begin
      if (need_sub_header) begin
        out.word = SUB_HEADER_WORD; // FIFO word follows next
      end else if (need_sub_footer) begin
        out.word = SUB_FOOTER_WORD;
        out.last = 1'b1;
      end else begin
        re = 1'b1;
        if (kind == WORD_FOOTER) begin
          out.last = 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_nxt = state;
    if (emit) begin
      case (state)
        OUTSIDE: begin
          // Either the real header or its substitute opens the frame
          state_nxt = INSIDE;
        end
        INSIDE: begin
          if (need_sub_footer) begin
            state_nxt = OUTSIDE; // Header is emitted on a later cycle
          end else if (kind == WORD_FOOTER) begin
            state_nxt = OUTSIDE;
          end
        end
        default: begin
          state_nxt = OUTSIDE;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state <= OUTSIDE;
    end else begin
      state <= state_nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Assertions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pop only from a non-empty FIFO while the merger grants this channel
  a_re_granted: assert property (
    @(posedge CLK) disable iff (!RESETN)
    re |-> (avail && grant && ready)
  ) else $error("channel_reader: pop without avail, grant or ready");

  // A repair word leaves the head word in the FIFO for the next cycle
  a_repair_keeps_head: assert property (
    @(posedge CLK) disable iff (!RESETN)
    (out.valid && !re && ready && grant) |=> (avail && ($past(din) == din))
  ) else $error("channel_reader: head word lost after repair");

endmodule

// ==== frame_merger/frame_merger.sv ====
`timescale 1ns/100ps

module frame_merger
  import frame_mixer_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RESETN,
  input  chan_word_t            ch0_word,
  input  chan_word_t            ch1_word,
  output logic                  grant0,
  output logic                  grant1,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  sending
);

  grant_state_e state;
  grant_state_e state_nxt;

  logic [DATA_WIDTH-1:0] sel_word;
  logic                  sel_valid;
  logic                  sel_last;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grant decode and channel select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign grant0 = (state == GRANT_CH0);
  assign grant1 = (state == GRANT_CH1);

  always_comb begin
    case (state)
      GRANT_CH0: begin
        sel_word  = ch0_word.word;
        sel_valid = ch0_word.valid;
        sel_last  = ch0_word.last;
      end
      GRANT_CH1: begin
        sel_word  = ch1_word.word;
        sel_valid = ch1_word.valid;
        sel_last  = ch1_word.last;
      end
      default: begin
        sel_word  = ch0_word.word;
        sel_valid = 1'b0; // Nobody granted in IDLE
        sel_last  = 1'b0;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame-level grant FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (ch0_word.pending) begin
          state_nxt = GRANT_CH0; // Fixed priority on channel 0
        end else if (ch1_word.pending) begin
          state_nxt = GRANT_CH1;
        end
      end
      GRANT_CH0, GRANT_CH1: begin
        if (sel_valid && sel_last) begin
          state_nxt = IDLE; // Rearbitrate after the frame ends
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      dout    <= '1;
      sending <= 1'b0;
    end else begin
      sending <= sel_valid;
      if (sel_valid) begin
        dout <= sel_word; // Holds value otherwise
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Assertions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_grant_onehot: assert property (
    @(posedge CLK) disable iff (!RESETN)
    !(grant0 && grant1)
  ) else $error("frame_merger: both channels granted");

  // Readers must stay silent unless granted
  a_ch0_valid_granted: assert property (
    @(posedge CLK) disable iff (!RESETN)
    ch0_word.valid |-> grant0
  ) else $error("frame_merger: channel 0 word without grant");

  a_ch1_valid_granted: assert property (
    @(posedge CLK) disable iff (!RESETN)
    ch1_word.valid |-> grant1
  ) else $error("frame_merger: channel 1 word without grant");

endmodule

// ==== source/frame_mixer_top.sv ====
`timescale 1ns/100ps

module frame_mixer_top
  import frame_mixer_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RESETN,
  input  logic [DATA_WIDTH-1:0] ch0_din,
  input  logic                  ch0_avail,
  input  logic [DATA_WIDTH-1:0] ch1_din,
  input  logic                  ch1_avail,
  input  logic                  ready,
  output logic                  ch0_re,
  output logic                  ch1_re,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  sending
);

  chan_word_t ch0_word;
  chan_word_t ch1_word;
  logic       grant0;
  logic       grant1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Channel readers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  channel_reader reader0 (
    .CLK    (CLK),
    .RESETN (RESETN),
    .din    (ch0_din),
    .avail  (ch0_avail),
    .grant  (grant0),
    .ready  (ready),
    .re     (ch0_re),
    .out    (ch0_word)
  );

  channel_reader reader1 (
    .CLK    (CLK),
    .RESETN (RESETN),
    .din    (ch1_din),
    .avail  (ch1_avail),
    .grant  (grant1),
    .ready  (ready),
    .re     (ch1_re),
    .out    (ch1_word)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Merger and output stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  frame_merger merger0 (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .ch0_word (ch0_word),
    .ch1_word (ch1_word),
    .grant0   (grant0),
    .grant1   (grant1),
    .dout     (dout),
    .sending  (sending)
  );

endmodule

// ==== dv/frame_mixer_tests.svh ====
  bit chan_inside[2]; // Expected frame state per channel

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word builders and expected-stream model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [DATA_WIDTH-1:0] header_word(input logic [15:0] tag);
    return {HEADER_ID, 40'h0, tag};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] footer_word(input logic [15:0] tag);
    return {8'hC5, 32'h0, tag, FOOTER_ID}; // Top bits 11, top byte not a header
  endfunction

  function automatic logic [DATA_WIDTH-1:0] data_word(input logic [15:0] tag);
    return {8'h3A, 40'h0, tag};
  endfunction

  function automatic word_kind_e classify_word(input logic [DATA_WIDTH-1:0] w);
    if (w[63:56] == HEADER_ID) begin
      return WORD_HEADER;
    end else if ((w[63:62] == 2'b11) && (w[7:0] == FOOTER_ID)) begin
      return WORD_FOOTER;
    end
    return WORD_DATA;
  endfunction

  // Appends what the output should carry for one pushed word
  task automatic model_word(input int ch, input logic [DATA_WIDTH-1:0] w);
    word_kind_e kind;
    kind = classify_word(w);
    if (!chan_inside[ch] && (kind != WORD_HEADER)) begin
      exp_q.push_back(64'hFEFF_FFFF_FFFF_FFFF);
      chan_inside[ch] = 1'b1;
    end else if (chan_inside[ch] && (kind == WORD_HEADER)) begin
      exp_q.push_back(64'hFFFF_FFFF_FFFF_FFEF);
      chan_inside[ch] = 1'b0;
    end
    exp_q.push_back(w);
    if (kind == WORD_HEADER) begin
      chan_inside[ch] = 1'b1;
    end else if (kind == WORD_FOOTER) begin
      chan_inside[ch] = 1'b0;
    end
  endtask

  task automatic push_word(input int ch, input logic [DATA_WIDTH-1:0] w);
    if (ch == 0) begin
      fifo0.push_back(w);
    end else begin
      fifo1.push_back(w);
    end
    model_word(ch, w);
    drive_fifo_outputs();
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  // Waits for the stream to drain, then compares it word by word
  task automatic finish_test(input string name);
    int waited;
    int n;
    waited = 0;
    while (((fifo0.size() != 0) || (fifo1.size() != 0) || (got_q.size() < exp_q.size()))
           && (waited < TEST_LIMIT)) begin
      @(posedge CLK);
      #2;
      waited++;
    end
    if (waited >= TEST_LIMIT) begin
      error_count++;
      $display("%s: output stream did not complete within %0d cycles", name, TEST_LIMIT);
    end
    repeat (4) next_cycle();
    check_value({name, ": word count"}, DATA_WIDTH'(got_q.size()), DATA_WIDTH'(exp_q.size()));
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      check_value($sformatf("%s: word %0d", name, i), got_q[i], exp_q[i]);
    end
    test_count++;
    $display("%s finished, %0d words, %0d errors", name, got_q.size(),
             error_count - errors_base);
    errors_base = error_count;
    got_q.delete();
    exp_q.delete();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_reset_state();
    @(posedge CLK);
    #2;
    check_value("sending after reset", DATA_WIDTH'(sending), 0);
    check_value("ch0_re after reset", DATA_WIDTH'(ch0_re), 0);
    check_value("ch1_re after reset", DATA_WIDTH'(ch1_re), 0);
    check_value("dout after reset", dout, '1);
    finish_test("reset_state");
  endtask

  task automatic test_single_frame();
    next_cycle();
    push_word(0, header_word(16'h0200));
    for (int i = 0; i < 3; i++) begin
      push_word(0, data_word(16'(16'h0201 + i)));
    end
    push_word(0, footer_word(16'h0204));
    finish_test("single_frame");
  endtask

  task automatic test_two_channels();
    int waited;
    next_cycle();
    push_word(0, header_word(16'h0300)); // Frame A on channel 0
    push_word(0, data_word(16'h0301));
    push_word(0, data_word(16'h0302));
    push_word(0, footer_word(16'h0303));
    push_word(1, header_word(16'h1300)); // Frame B on channel 1
    for (int i = 0; i < 4; i++) begin
      push_word(1, data_word(16'(16'h1301 + i)));
    end
    push_word(1, footer_word(16'h1305));
    waited = 0;
    while (!ch1_re && (waited < TEST_LIMIT)) begin
      @(posedge CLK);
      #2;
      waited++;
    end
    if (waited >= TEST_LIMIT) begin
      error_count++;
      $display("two_channels: channel 1 never started its frame");
    end
    next_cycle();
    push_word(0, header_word(16'h0310)); // Frame C arrives mid frame B
    push_word(0, data_word(16'h0311));
    push_word(0, footer_word(16'h0312));
    finish_test("two_channels");
  endtask

  task automatic test_missing_footer();
    next_cycle();
    push_word(0, header_word(16'h0400));
    push_word(0, data_word(16'h0401));
    push_word(0, data_word(16'h0402));
    push_word(0, header_word(16'h0410)); // No footer before this
    push_word(0, data_word(16'h0411));
    push_word(0, footer_word(16'h0412));
    finish_test("missing_footer");
  endtask

  task automatic test_missing_header();
    next_cycle();
    push_word(1, data_word(16'h1500)); // Data outside a frame
    push_word(1, data_word(16'h1501));
    push_word(1, footer_word(16'h1502));
    push_word(1, footer_word(16'h1503)); // Lone footer
    finish_test("missing_header");
  endtask

  task automatic test_random_ready();
    int pick;
    logic [15:0] tag;
    random_ready = 1'b1;
    next_cycle();
    for (int ch = 0; ch < 2; ch++) begin
      for (int i = 0; i < 24; i++) begin
        pick = ($random(seed) & 32'h7fff_ffff) % 5;
        tag  = 16'((ch * 16'h1000) + 16'h0600 + i);
        if (pick == 3) begin
          push_word(ch, header_word(tag));
        end else if (pick == 4) begin
          push_word(ch, footer_word(tag));
        end else begin
          push_word(ch, data_word(tag));
        end
      end
      push_word(ch, footer_word(16'(16'h0680 + ch))); // Every channel ends closed
    end
    finish_test("random_ready");
    random_ready = 1'b0;
  endtask

// ==== dv/frame_mixer_tb.sv ====
`timescale 1ns/100ps

module frame_mixer_tb
  import frame_mixer_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 10;
  localparam int TEST_LIMIT      = 600;  // Per test wait bound in cycles
  localparam int WATCHDOG_CYCLES = 4000; // Six tests well under 600 cycles each, plus reset

  logic                  CLK;
  logic                  RESETN;
  logic [DATA_WIDTH-1:0] ch0_din;
  logic                  ch0_avail;
  logic [DATA_WIDTH-1:0] ch1_din;
  logic                  ch1_avail;
  logic                  ready;
  logic                  ch0_re;
  logic                  ch1_re;
  logic [DATA_WIDTH-1:0] dout;
  logic                  sending;

  logic [DATA_WIDTH-1:0] fifo0[$];
  logic [DATA_WIDTH-1:0] fifo1[$];
  logic [DATA_WIDTH-1:0] exp_q[$];
  logic [DATA_WIDTH-1:0] got_q[$];

  integer seed;
  bit     random_ready = 1'b0;
  int     error_count  = 0;
  int     check_count  = 0;
  int     test_count   = 0;
  int     errors_base  = 0;

  logic                  pop0 = 1'b0;
  logic                  pop1 = 1'b0;
  logic                  prev_live  = 1'b0;
  logic                  prev_ready = 1'b0;
  logic                  prev_re0   = 1'b0;
  logic                  prev_re1   = 1'b0;
  logic [DATA_WIDTH-1:0] prev_din0  = '0;
  logic [DATA_WIDTH-1:0] prev_din1  = '0;

  frame_mixer_top dut0 (
    .CLK       (CLK),
    .RESETN    (RESETN),
    .ch0_din   (ch0_din),
    .ch0_avail (ch0_avail),
    .ch1_din   (ch1_din),
    .ch1_avail (ch1_avail),
    .ready     (ready),
    .ch0_re    (ch0_re),
    .ch1_re    (ch1_re),
    .dout      (dout),
    .sending   (sending)
  );

  task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Head of each queue shows up as din, non-empty as avail
  task automatic drive_fifo_outputs();
    ch0_avail = (fifo0.size() != 0);
    ch0_din   = (fifo0.size() != 0) ? fifo0[0] : '0;
    ch1_avail = (fifo1.size() != 0);
    ch1_din   = (fifo1.size() != 0) ? fifo1[0] : '0;
  endtask

  `include "frame_mixer_tests.svh"

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock, FIFO models and monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    CLK = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) CLK = ~CLK;
    end
  end

  always @(posedge CLK) begin
    pop0 = ch0_re;
    pop1 = ch1_re;
    #1;
    if (pop0 && (fifo0.size() != 0)) begin
      fifo0.delete(0);
    end
    if (pop1 && (fifo1.size() != 0)) begin
      fifo1.delete(0);
    end
    drive_fifo_outputs();
    if (random_ready) begin
      ready = (($random(seed) & 32'sd1) != 0); // Low about half the time
    end else begin
      ready = 1'b1;
    end
  end

  // Values seen here are the ones from the cycle that ends at this edge
  always @(posedge CLK) begin
    if (RESETN && prev_live) begin
      if (sending) begin
        got_q.push_back(dout);
      end
      if (prev_re0) begin
        check_value("sending one cycle after ch0_re", DATA_WIDTH'(sending), 1);
        check_value("dout one cycle after ch0_re", dout, prev_din0);
      end
      if (prev_re1) begin
        check_value("sending one cycle after ch1_re", DATA_WIDTH'(sending), 1);
        check_value("dout one cycle after ch1_re", dout, prev_din1);
      end
      check_value("sending after ready low", DATA_WIDTH'(sending && !prev_ready), 0);
    end
    prev_live  = RESETN;
    prev_ready = ready;
    prev_re0   = ch0_re;
    prev_re1   = ch1_re;
    prev_din0  = ch0_din;
    prev_din1  = ch1_din;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog fired: the run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    seed      = 49888;
    RESETN    = 1'b0;
    ch0_din   = '0;
    ch0_avail = 1'b0;
    ch1_din   = '0;
    ch1_avail = 1'b0;
    ready     = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RESETN = 1'b1;
    test_reset_state();
    test_single_frame();
    test_two_channels();
    test_missing_footer();
    test_missing_header();
    test_random_ready();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== frame_mixer.f ====
+incdir+dv
common/frame_mixer_pkg.sv
channel_reader/channel_reader.sv
frame_merger/frame_merger.sv
source/frame_mixer_top.sv
dv/frame_mixer_tb.sv

// ==== Makefile ====
# Verilator build and run for frame_mixer

SIM = obj_dir/Vframe_mixer_tb

SOURCES = frame_mixer.f \
          common/frame_mixer_pkg.sv \
          channel_reader/channel_reader.sv \
          frame_merger/frame_merger.sv \
          source/frame_mixer_top.sv \
          dv/frame_mixer_tb.sv \
          dv/frame_mixer_tests.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES)
	verilator --binary --timing --assert -f frame_mixer.f --top-module frame_mixer_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
